/* dv/decode_tb.sv */
module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 8;
    // Redirect condition and target source of a table entry
    localparam logic [2:0] c_none = 3'd0, c_always = 3'd1, c_eq = 3'd2, c_ne = 3'd3;
    localparam logic [2:0] c_lez = 3'd4, c_gtz = 3'd5;
    localparam logic [1:0] t_branch = 2'd0, t_jump = 2'd1, t_reg = 2'd2;

    // Flag bits from the top are use_shift use_imm unsigned mem_read mem_write wb_from_mem
    // write_reg trap
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] next_pc;
        logic [2:0]  cond;
        logic [1:0]  tgt;
        logic [2:0]  alu;
        logic [1:0]  shift;
        logic [7:0]  flags;
        logic        zext;
        logic        dest_rd;
    } entry_t;

    logic clock, reset, in_valid, in_ready, pc_redirect, ex_valid, ex_ready;
    logic [31:0] in_instruction, in_next_pc, pc_target, ex_rega, ex_regb, ex_imm, wb_data;
    logic ex_use_shift, ex_use_imm, ex_unsigned, ex_mem_read, ex_mem_write;
    logic ex_wb_from_mem, ex_write_reg, ex_trap_overflow, wb_write;
    logic [4:0] ex_dest, ex_shamt, wb_addr;
    decode_pkg::pc_type_t  pc_type;
    decode_pkg::alu_op_t   ex_alu_op;
    decode_pkg::shift_op_t ex_shift_op;

    entry_t      table_q[$];
    string       name_q[$];
    logic [31:0] model_regs [0:31];
    logic [31:0] lfsr_state = 32'h9857;
    int          errors = 0;
    bit          table_built = 1'b0;

    tb_clock clock_gen (.clock(clock), .reset(reset));

    decode_top dut (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic next_random(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] r_type(int rs, int rt, int rd, int shamt, int funct);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), 6'(funct)};
    endfunction

    function automatic logic [31:0] i_type(int op, int rs, int rt, int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic show_mismatch(string test, string field, logic [31:0] expected,
                                 logic [31:0] actual);
        errors++;
        $display("Fail %s %s: expected %h, actual %h", test, field, expected, actual);
    endtask

    task automatic protocol_error(string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic store(string name, logic [31:0] instr, logic [2:0] cond, logic [1:0] tgt,
                         logic [2:0] alu, logic [1:0] shift, logic [7:0] flags,
                         logic zext, logic dest_rd);
        logic [31:0] next_pc;
        // Upper nibble set so jump targets carry region bits
        next_pc = 32'h8040_0000 + 32'(table_q.size() * 4);
        table_q.push_back(entry_t'({instr, next_pc, cond, tgt, alu, shift, flags, zext, dest_rd}));
        name_q.push_back(name);
    endtask

    task automatic add_op(string name, logic [31:0] instr, decode_pkg::alu_op_t alu,
                          logic [7:0] flags, logic zext, logic dest_rd);
        store(name, instr, c_none, t_branch, alu, decode_pkg::shift_sll, flags, zext, dest_rd);
    endtask

    task automatic add_shift(string name, logic [31:0] instr, decode_pkg::shift_op_t shift);
        store(name, instr, c_none, t_branch, decode_pkg::alu_add, shift, 8'h82, 1'b0, 1'b1);
    endtask

    task automatic add_redirect(string name, logic [31:0] instr, logic [2:0] cond,
                                logic [1:0] tgt);
        store(name, instr, cond, tgt, decode_pkg::alu_add, decode_pkg::shift_sll, 8'h00,
              1'b0, 1'b0);
    endtask

    task automatic build_table();
        add_op("zero_read", r_type(31, 17, 4, 0, 'h25), decode_pkg::alu_or, 8'h02, 1'b0, 1'b1);
        add_op("add", r_type(1, 2, 3, 0, 'h20), decode_pkg::alu_add, 8'h03, 1'b0, 1'b1);
        add_op("addu", r_type(4, 5, 6, 0, 'h21), decode_pkg::alu_add, 8'h22, 1'b0, 1'b1);
        add_op("sub", r_type(7, 8, 9, 0, 'h22), decode_pkg::alu_sub, 8'h03, 1'b0, 1'b1);
        add_op("subu", r_type(10, 11, 12, 0, 'h23), decode_pkg::alu_sub, 8'h22, 1'b0, 1'b1);
        add_op("and", r_type(13, 14, 15, 0, 'h24), decode_pkg::alu_and, 8'h02, 1'b0, 1'b1);
        add_op("or", r_type(16, 17, 18, 0, 'h25), decode_pkg::alu_or, 8'h02, 1'b0, 1'b1);
        add_op("xor", r_type(19, 20, 21, 0, 'h26), decode_pkg::alu_xor, 8'h02, 1'b0, 1'b1);
        add_op("nor", r_type(22, 23, 24, 0, 'h27), decode_pkg::alu_nor, 8'h02, 1'b0, 1'b1);
        add_op("slt", r_type(25, 26, 27, 0, 'h2a), decode_pkg::alu_slt, 8'h02, 1'b0, 1'b1);
        add_op("sltu", r_type(28, 29, 30, 0, 'h2b), decode_pkg::alu_slt, 8'h22, 1'b0, 1'b1);
        add_op("or_r0", r_type(0, 31, 1, 0, 'h25), decode_pkg::alu_or, 8'h02, 1'b0, 1'b1);
        add_shift("sll", r_type(0, 2, 3, 4, 'h00), decode_pkg::shift_sll);
        add_shift("srl", r_type(0, 5, 6, 17, 'h02), decode_pkg::shift_srl);
        add_shift("sra", r_type(0, 8, 9, 31, 'h03), decode_pkg::shift_sra);
        add_op("addi", i_type('h08, 3, 4, 'hfff0), decode_pkg::alu_add, 8'h43, 1'b0, 1'b0);
        add_op("addiu", i_type('h09, 5, 6, 'h8001), decode_pkg::alu_add, 8'h62, 1'b0, 1'b0);
        add_op("slti", i_type('h0a, 7, 8, 'h7fff), decode_pkg::alu_slt, 8'h42, 1'b0, 1'b0);
        add_op("sltiu", i_type('h0b, 9, 10, 'h9000), decode_pkg::alu_slt, 8'h62, 1'b0, 1'b0);
        add_op("andi", i_type('h0c, 11, 12, 'h8421), decode_pkg::alu_and, 8'h42, 1'b1, 1'b0);
        add_op("ori", i_type('h0d, 13, 14, 'hf00f), decode_pkg::alu_or, 8'h42, 1'b1, 1'b0);
        add_op("xori", i_type('h0e, 15, 16, 'hc0de), decode_pkg::alu_xor, 8'h42, 1'b1, 1'b0);
        add_op("lw", i_type('h23, 17, 18, 'hfffc), decode_pkg::alu_add, 8'h56, 1'b0, 1'b0);
        add_op("sw", i_type('h2b, 19, 20, 'h0040), decode_pkg::alu_add, 8'h48, 1'b0, 1'b0);
        add_redirect("beq_taken", i_type('h04, 5, 5, 'hfff8), c_eq, t_branch);
        add_redirect("beq_not", i_type('h04, 5, 6, 'h0010), c_eq, t_branch);
        add_redirect("bne_taken", i_type('h05, 7, 8, 'h0020), c_ne, t_branch);
        add_redirect("bne_not", i_type('h05, 7, 7, 'hff00), c_ne, t_branch);
        add_redirect("blez", i_type('h06, 9, 0, 'h0004), c_lez, t_branch);
        add_redirect("bgtz", i_type('h07, 10, 0, 'h8000), c_gtz, t_branch);
        add_redirect("blez_r0", i_type('h06, 0, 0, 'h0100), c_lez, t_branch);
        add_redirect("bgtz_r0", i_type('h07, 0, 0, 'h0100), c_gtz, t_branch);
        add_redirect("j", {6'h02, 26'h2a5_5a5c}, c_always, t_jump);
        add_redirect("jr", r_type(21, 0, 0, 0, 'h08), c_always, t_reg);
        add_op("unknown_op", {6'h3f, 26'h155_aa55}, decode_pkg::alu_add, 8'h00, 1'b0, 1'b0);
        add_op("unknown_fn", r_type(1, 2, 3, 0, 'h3f), decode_pkg::alu_add, 8'h00, 1'b0, 1'b0);
    endtask

    // Sample just after the falling edge until the stage can take input
    task automatic wait_ready();
        #1;
        while (!in_ready) begin
            @(negedge clock);
            #1;
        end
    endtask

    task automatic apply_entry(int idx);
        entry_t      e;
        string       n;
        logic [31:0] rs_val, rt_val, imm_ext, exp_target;
        logic [7:0]  got_flags;
        logic [4:0]  exp_dest;
        logic        exp_redirect;
        e = table_q[idx];
        n = name_q[idx];
        rs_val = model_regs[e.instr[25:21]];
        rt_val = model_regs[e.instr[20:16]];
        imm_ext = e.zext ? {16'h0000, e.instr[15:0]} : {{16{e.instr[15]}}, e.instr[15:0]};
        exp_dest = e.dest_rd ? e.instr[15:11] : e.instr[20:16];
        case (e.cond)
            c_always: exp_redirect = 1'b1;
            c_eq:     exp_redirect = (rs_val == rt_val);
            c_ne:     exp_redirect = (rs_val != rt_val);
            c_lez:    exp_redirect = ($signed(rs_val) <= 0);
            c_gtz:    exp_redirect = ($signed(rs_val) > 0);
            default:  exp_redirect = 1'b0;
        endcase
        case (e.tgt)
            t_jump:  exp_target = {e.next_pc[31:28], e.instr[25:0], 2'b00};
            t_reg:   exp_target = rs_val;
            default: exp_target = e.next_pc + {{14{e.instr[15]}}, e.instr[15:0], 2'b00};
        endcase

        @(negedge clock);
        in_instruction = e.instr;
        in_next_pc = e.next_pc;
        in_valid = 1'b1;
        ex_ready = 1'b1;
        wait_ready();
        if (pc_redirect !== exp_redirect)
            show_mismatch(n, "pc_redirect", 32'(exp_redirect), 32'(pc_redirect));
        if (exp_redirect && pc_target !== exp_target)
            show_mismatch(n, "pc_target", exp_target, pc_target);
        if (e.cond != c_none && pc_type !== e.tgt)
            show_mismatch(n, "pc_type", 32'(e.tgt), 32'(pc_type));

        // Bundle shows up one rising edge after acceptance
        @(posedge clock);
        @(negedge clock);
        in_valid = 1'b0;
        got_flags = {ex_use_shift, ex_use_imm, ex_unsigned, ex_mem_read, ex_mem_write,
                     ex_wb_from_mem, ex_write_reg, ex_trap_overflow};
        if (ex_valid !== 1'b1) protocol_error({n, ": ex_valid low one clock after acceptance"});
        if (got_flags !== e.flags) show_mismatch(n, "flags", 32'(e.flags), 32'(got_flags));
        if (ex_alu_op !== e.alu) show_mismatch(n, "alu_op", 32'(e.alu), 32'(ex_alu_op));
        if (ex_shift_op !== e.shift) show_mismatch(n, "shift_op", 32'(e.shift), 32'(ex_shift_op));
        if (ex_dest !== exp_dest) show_mismatch(n, "dest", 32'(exp_dest), 32'(ex_dest));
        if (ex_rega !== rs_val) show_mismatch(n, "rega", rs_val, ex_rega);
        if (ex_regb !== rt_val) show_mismatch(n, "regb", rt_val, ex_regb);
        if (ex_imm !== imm_ext) show_mismatch(n, "imm", imm_ext, ex_imm);
        if (ex_shamt !== e.instr[10:6])
            show_mismatch(n, "shamt", 32'(e.instr[10:6]), 32'(ex_shamt));
    endtask

    task automatic load_registers();
        logic [31:0] value;
        for (int i = 0; i < 32; i++) begin
            next_random(value);
            @(negedge clock);
            wb_write = 1'b1;
            wb_addr = 5'(i);
            wb_data = value;
            // Register 0 keeps reading zero
            model_regs[i] = (i == 0) ? '0 : value;
        end
        @(negedge clock);
        wb_write = 1'b0;
    endtask

    task automatic check_back_pressure();
        logic [105:0] held;
        @(negedge clock);
        in_instruction = r_type(1, 2, 14, 0, 'h20);
        in_valid = 1'b1;
        ex_ready = 1'b0;
        wait_ready();
        @(posedge clock);
        @(negedge clock);
        // A jump waits behind the stalled add
        in_instruction = {6'h02, 26'h0155_aa0};
        in_next_pc = 32'h4000_0010;
        held = {ex_rega, ex_regb, ex_imm, ex_dest, ex_alu_op, ex_write_reg, ex_valid};
        if (ex_valid !== 1'b1) protocol_error("first instruction not taken in before the stall");
        if (ex_rega !== model_regs[1])
            show_mismatch("back_pressure", "rega", model_regs[1], ex_rega);
        repeat (5) begin
            #1;
            if (in_ready !== 1'b0) protocol_error("in_ready high while execute stalls");
            if (pc_redirect !== 1'b0) protocol_error("redirect issued while the stage is stalled");
            @(negedge clock);
            if ({ex_rega, ex_regb, ex_imm, ex_dest, ex_alu_op, ex_write_reg, ex_valid} !== held)
                protocol_error("ex outputs changed while execute stalls");
        end
        ex_ready = 1'b1;
        #1;
        if (in_ready !== 1'b1) protocol_error("in_ready stayed low after execute became ready");
        if (pc_redirect !== 1'b1) protocol_error("waiting jump did not redirect after release");
        @(posedge clock);
        @(negedge clock);
        in_valid = 1'b0;
        if (ex_valid !== 1'b1 || ex_write_reg !== 1'b0)
            protocol_error("waiting jump not taken in after release");
    endtask

    initial begin
        wait (table_built);
        repeat (table_q.size() * 20 + reset_cycles) @(posedge clock);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        in_valid = 1'b0;
        ex_ready = 1'b1;
        // Idle jump that must not redirect while in_valid is low
        in_instruction = {6'h02, 26'h0};
        in_next_pc = '0;
        wb_write = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        table_built = 1'b1;

        wait (reset === 1'b1);
        @(negedge clock);
        if (ex_valid !== 1'b0) show_mismatch("reset", "ex_valid", 0, 32'(ex_valid));
        if (ex_write_reg !== 1'b0) show_mismatch("reset", "write_reg", 0, 32'(ex_write_reg));
        if (ex_mem_read !== 1'b0) show_mismatch("reset", "mem_read", 0, 32'(ex_mem_read));
        if (ex_mem_write !== 1'b0) show_mismatch("reset", "mem_write", 0, 32'(ex_mem_write));
        if (pc_redirect !== 1'b0) show_mismatch("reset", "pc_redirect", 0, 32'(pc_redirect));
        if (in_ready !== 1'b1) show_mismatch("reset", "in_ready", 1, 32'(in_ready));

        // First entry reads the cleared register file
        apply_entry(0);
        load_registers();
        for (int i = 1; i < table_q.size(); i++) begin
            apply_entry(i);
        end
        check_back_pressure();

        $display("Decode stage checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end
endmodule

/* dv/tb_clock.sv */
module tb_clock (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Active low reset held for eight cycles
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end
endmodule

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module decode_tb \
    -f src.f -o decode_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -q "Verification failed" sim.log
found=$?
if [ $found -eq 0 ]; then
    exit 1
elif [ $found -ne 1 ]; then
    echo "Could not search sim.log"
    exit 1
fi
exit 0

/* src.f */
verilog/decode_pkg.sv
verilog/ctrl_bus_if.sv
verilog/control_unit.sv
verilog/branch_unit.sv
verilog/register_file.sv
verilog/id_ex_register.sv
verilog/decode_top.sv
dv/tb_clock.sv
dv/decode_tb.sv

/* verilog/branch_unit.sv */
module branch_unit (
    input  logic [decode_pkg::data_width-1:0] instruction,
    input  logic [decode_pkg::data_width-1:0] next_pc,
    input  logic [decode_pkg::data_width-1:0] rs_data,
    input  logic [decode_pkg::data_width-1:0] rt_data,
    input  logic                              enable,
    ctrl_bus_if.branch                        ctrl,
    output logic                              pc_redirect,
    output logic [decode_pkg::data_width-1:0] pc_target
);

    logic                              taken;
    logic [decode_pkg::data_width-1:0] imm_ext;
    logic [decode_pkg::data_width-1:0] branch_target;
    logic [decode_pkg::data_width-1:0] jump_target;

    always_comb begin
        case (ctrl.comp_op)
            decode_pkg::comp_eq:  taken = (rs_data == rt_data);
            decode_pkg::comp_ne:  taken = (rs_data != rt_data);
            decode_pkg::comp_lez: taken = ($signed(rs_data) <= 0);
            default:              taken = ($signed(rs_data) > 0);
        endcase
    end

    assign imm_ext = {{16{instruction[decode_pkg::imm_msb]}},
                      instruction[decode_pkg::imm_msb:decode_pkg::imm_lsb]};
    assign branch_target = next_pc + (imm_ext << 2);

    // Region index keeps the upper nibble of the next PC
    assign jump_target = {next_pc[31:28],
                          instruction[decode_pkg::index_msb:decode_pkg::index_lsb], 2'b00};

    always_comb begin
        case (ctrl.pc_type)
            decode_pkg::pc_jump:     pc_target = jump_target;
            decode_pkg::pc_register: pc_target = rs_data;
            default:                 pc_target = branch_target;
        endcase
    end

    assign pc_redirect = enable && ((ctrl.branch_kind == decode_pkg::branch_always) ||
                         ((ctrl.branch_kind == decode_pkg::branch_conditional) && taken));

endmodule

/* verilog/control_unit.sv */
module control_unit (
    input  logic [decode_pkg::data_width-1:0] instruction,
    ctrl_bus_if.decoder                       ctrl
);

    decode_pkg::opcode_t op;
    decode_pkg::funct_t  funct;

    assign op    = decode_pkg::opcode_t'(instruction[decode_pkg::op_msb:decode_pkg::op_lsb]);
    assign funct = decode_pkg::funct_t'(instruction[decode_pkg::funct_msb:decode_pkg::funct_lsb]);

    always_comb begin
        // No-op bundle unless a known encoding matches
        ctrl.alu_op        = decode_pkg::alu_add;
        ctrl.shift_op      = decode_pkg::shift_sll;
        ctrl.use_shift     = 1'b0;
        ctrl.use_imm       = 1'b0;
        ctrl.zero_ext_imm  = 1'b0;
        ctrl.unsigned_op   = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.wb_from_mem   = 1'b0;
        ctrl.write_reg     = 1'b0;
        ctrl.trap_overflow = 1'b0;
        ctrl.dest_is_rd    = 1'b0;
        ctrl.branch_kind   = decode_pkg::branch_none;
        ctrl.comp_op       = decode_pkg::comp_eq;
        ctrl.pc_type       = decode_pkg::pc_branch;

        case (op)
            decode_pkg::op_special: begin
                ctrl.write_reg  = 1'b1;
                ctrl.dest_is_rd = 1'b1;
                case (funct)
                    decode_pkg::fn_add: ctrl.trap_overflow = 1'b1;
                    decode_pkg::fn_addu: ctrl.unsigned_op = 1'b1;
                    decode_pkg::fn_sub: begin
                        ctrl.alu_op        = decode_pkg::alu_sub;
                        ctrl.trap_overflow = 1'b1;
                    end
                    decode_pkg::fn_subu: begin
                        ctrl.alu_op      = decode_pkg::alu_sub;
                        ctrl.unsigned_op = 1'b1;
                    end
                    decode_pkg::fn_and: ctrl.alu_op = decode_pkg::alu_and;
                    decode_pkg::fn_or:  ctrl.alu_op = decode_pkg::alu_or;
                    decode_pkg::fn_xor: ctrl.alu_op = decode_pkg::alu_xor;
                    decode_pkg::fn_nor: ctrl.alu_op = decode_pkg::alu_nor;
                    decode_pkg::fn_slt: ctrl.alu_op = decode_pkg::alu_slt;
                    decode_pkg::fn_sltu: begin
                        ctrl.alu_op      = decode_pkg::alu_slt;
                        ctrl.unsigned_op = 1'b1;
                    end
                    decode_pkg::fn_sll: ctrl.use_shift = 1'b1;
                    decode_pkg::fn_srl: begin
                        ctrl.use_shift = 1'b1;
                        ctrl.shift_op  = decode_pkg::shift_srl;
                    end
                    decode_pkg::fn_sra: begin
                        ctrl.use_shift = 1'b1;
                        ctrl.shift_op  = decode_pkg::shift_sra;
                    end
                    decode_pkg::fn_jr: begin
                        ctrl.write_reg   = 1'b0;
                        ctrl.dest_is_rd  = 1'b0;
                        ctrl.branch_kind = decode_pkg::branch_always;
                        ctrl.pc_type     = decode_pkg::pc_register;
                    end
                    default: begin
                        ctrl.write_reg  = 1'b0;
                        ctrl.dest_is_rd = 1'b0;
                    end
                endcase
            end
            decode_pkg::op_addi, decode_pkg::op_addiu, decode_pkg::op_slti,
            decode_pkg::op_sltiu, decode_pkg::op_andi, decode_pkg::op_ori,
            decode_pkg::op_xori: begin
                ctrl.use_imm   = 1'b1;
                ctrl.write_reg = 1'b1;
                case (op)
                    decode_pkg::op_addi:  ctrl.trap_overflow = 1'b1;
                    decode_pkg::op_addiu: ctrl.unsigned_op = 1'b1;
                    decode_pkg::op_slti:  ctrl.alu_op = decode_pkg::alu_slt;
                    decode_pkg::op_sltiu: begin
                        ctrl.alu_op      = decode_pkg::alu_slt;
                        ctrl.unsigned_op = 1'b1;
                    end
                    decode_pkg::op_andi: ctrl.alu_op = decode_pkg::alu_and;
                    decode_pkg::op_ori:  ctrl.alu_op = decode_pkg::alu_or;
                    default:             ctrl.alu_op = decode_pkg::alu_xor;
                endcase
                // Logical immediates are zero extended
                ctrl.zero_ext_imm = (op == decode_pkg::op_andi) || (op == decode_pkg::op_ori)
                                    || (op == decode_pkg::op_xori);
            end
            decode_pkg::op_lw: begin
                ctrl.use_imm     = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.wb_from_mem = 1'b1;
                ctrl.write_reg   = 1'b1;
            end
            decode_pkg::op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            decode_pkg::op_beq, decode_pkg::op_bne, decode_pkg::op_blez,
            decode_pkg::op_bgtz: begin
                ctrl.branch_kind = decode_pkg::branch_conditional;
                // Low two opcode bits select the comparison
                ctrl.comp_op = decode_pkg::comp_op_t'(op[1:0]);
            end
            decode_pkg::op_j: begin
                ctrl.branch_kind = decode_pkg::branch_always;
                ctrl.pc_type     = decode_pkg::pc_jump;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/ctrl_bus_if.sv */
interface ctrl_bus_if;

    decode_pkg::alu_op_t      alu_op;
    decode_pkg::shift_op_t    shift_op;
    logic                     use_shift;
    logic                     use_imm;
    logic                     zero_ext_imm;
    logic                     unsigned_op;
    logic                     mem_read;
    logic                     mem_write;
    logic                     wb_from_mem;
    logic                     write_reg;
    logic                     trap_overflow;
    logic                     dest_is_rd;
    decode_pkg::branch_kind_t branch_kind;
    decode_pkg::comp_op_t     comp_op;
    decode_pkg::pc_type_t     pc_type;

    modport decoder (
        output alu_op, shift_op, use_shift, use_imm, zero_ext_imm, unsigned_op,
        output mem_read, mem_write, wb_from_mem, write_reg, trap_overflow, dest_is_rd,
        output branch_kind, comp_op, pc_type
    );

    modport branch (input branch_kind, comp_op, pc_type);

    modport stage (
        input alu_op, shift_op, use_shift, use_imm, zero_ext_imm, unsigned_op,
        input mem_read, mem_write, wb_from_mem, write_reg, trap_overflow, dest_is_rd
    );

endinterface

/* verilog/decode_pkg.sv */
package decode_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    // Instruction field positions
    localparam int op_msb    = 31;
    localparam int op_lsb    = 26;
    localparam int rs_msb    = 25;
    localparam int rs_lsb    = 21;
    localparam int rt_msb    = 20;
    localparam int rt_lsb    = 16;
    localparam int rd_msb    = 15;
    localparam int rd_lsb    = 11;
    localparam int shamt_msb = 10;
    localparam int shamt_lsb = 6;
    localparam int funct_msb = 5;
    localparam int funct_lsb = 0;
    localparam int imm_msb   = 15;
    localparam int imm_lsb   = 0;
    localparam int index_msb = 25;
    localparam int index_lsb = 0;

    typedef enum logic [5:0] {
        op_special = 6'h00, op_j     = 6'h02, op_beq   = 6'h04, op_bne  = 6'h05,
        op_blez    = 6'h06, op_bgtz  = 6'h07, op_addi  = 6'h08, op_addiu = 6'h09,
        op_slti    = 6'h0a, op_sltiu = 6'h0b, op_andi  = 6'h0c, op_ori  = 6'h0d,
        op_xori    = 6'h0e, op_lw    = 6'h23, op_sw    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra = 6'h03, fn_jr  = 6'h08,
        fn_add  = 6'h20, fn_addu = 6'h21, fn_sub = 6'h22, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor = 6'h26, fn_nor = 6'h27,
        fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        shift_sll, shift_srl, shift_sra
    } shift_op_t;

    typedef enum logic [1:0] {
        comp_eq, comp_ne, comp_lez, comp_gtz
    } comp_op_t;

    typedef enum logic [1:0] {
        branch_none, branch_always, branch_conditional
    } branch_kind_t;

    // Where the redirect target comes from
    typedef enum logic [1:0] {
        pc_branch, pc_jump, pc_register
    } pc_type_t;

endpackage

/* verilog/decode_top.sv */
module decode_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [decode_pkg::data_width-1:0]     in_instruction,
    input  logic [decode_pkg::data_width-1:0]     in_next_pc,
    output logic                                  pc_redirect,
    output logic [decode_pkg::data_width-1:0]     pc_target,
    output decode_pkg::pc_type_t                  pc_type,
    output logic                                  ex_valid,
    input  logic                                  ex_ready,
    output decode_pkg::alu_op_t                   ex_alu_op,
    output decode_pkg::shift_op_t                 ex_shift_op,
    output logic                                  ex_use_shift,
    output logic                                  ex_use_imm,
    output logic                                  ex_unsigned,
    output logic                                  ex_mem_read,
    output logic                                  ex_mem_write,
    output logic                                  ex_wb_from_mem,
    output logic                                  ex_write_reg,
    output logic                                  ex_trap_overflow,
    output logic [decode_pkg::reg_addr_width-1:0] ex_dest,
    output logic [decode_pkg::data_width-1:0]     ex_rega,
    output logic [decode_pkg::data_width-1:0]     ex_regb,
    output logic [decode_pkg::data_width-1:0]     ex_imm,
    output logic [4:0]                            ex_shamt,
    input  logic                                  wb_write,
    input  logic [decode_pkg::reg_addr_width-1:0] wb_addr,
    input  logic [decode_pkg::data_width-1:0]     wb_data
);

    logic [decode_pkg::data_width-1:0] rs_data;
    logic [decode_pkg::data_width-1:0] rt_data;
    logic                              accept;

    ctrl_bus_if ctrl_bus ();

    assign accept  = in_valid && in_ready;
    assign pc_type = ctrl_bus.pc_type;

    register_file u_register_file (
        .clock      (clock),
        .reset      (reset),
        .addr_a     (in_instruction[decode_pkg::rs_msb:decode_pkg::rs_lsb]),
        .addr_b     (in_instruction[decode_pkg::rt_msb:decode_pkg::rt_lsb]),
        .data_a     (rs_data),
        .data_b     (rt_data),
        .write      (wb_write),
        .write_addr (wb_addr),
        .write_data (wb_data)
    );

    control_unit u_control_unit (
        .instruction (in_instruction),
        .ctrl        (ctrl_bus.decoder)
    );

    // Redirect only for an instruction accepted this cycle
    branch_unit u_branch_unit (
        .instruction (in_instruction),
        .next_pc     (in_next_pc),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .enable      (accept),
        .ctrl        (ctrl_bus.branch),
        .pc_redirect (pc_redirect),
        .pc_target   (pc_target)
    );

    id_ex_register u_id_ex_register (
        .clock (clock), .reset (reset),
        .instruction (in_instruction), .rs_data (rs_data), .rt_data (rt_data),
        .ctrl (ctrl_bus.stage),
        .in_valid (in_valid), .ex_ready (ex_ready), .in_ready (in_ready),
        .ex_valid (ex_valid), .ex_alu_op (ex_alu_op), .ex_shift_op (ex_shift_op),
        .ex_use_shift (ex_use_shift), .ex_use_imm (ex_use_imm), .ex_unsigned (ex_unsigned),
        .ex_mem_read (ex_mem_read), .ex_mem_write (ex_mem_write),
        .ex_wb_from_mem (ex_wb_from_mem), .ex_write_reg (ex_write_reg),
        .ex_trap_overflow (ex_trap_overflow), .ex_dest (ex_dest),
        .ex_rega (ex_rega), .ex_regb (ex_regb), .ex_imm (ex_imm), .ex_shamt (ex_shamt)
    );

endmodule

/* verilog/id_ex_register.sv */
module id_ex_register (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [decode_pkg::data_width-1:0]     instruction,
    input  logic [decode_pkg::data_width-1:0]     rs_data,
    input  logic [decode_pkg::data_width-1:0]     rt_data,
    ctrl_bus_if.stage                             ctrl,
    input  logic                                  in_valid,
    input  logic                                  ex_ready,
    output logic                                  in_ready,
    output logic                                  ex_valid,
    output decode_pkg::alu_op_t                   ex_alu_op,
    output decode_pkg::shift_op_t                 ex_shift_op,
    output logic                                  ex_use_shift,
    output logic                                  ex_use_imm,
    output logic                                  ex_unsigned,
    output logic                                  ex_mem_read,
    output logic                                  ex_mem_write,
    output logic                                  ex_wb_from_mem,
    output logic                                  ex_write_reg,
    output logic                                  ex_trap_overflow,
    output logic [decode_pkg::reg_addr_width-1:0] ex_dest,
    output logic [decode_pkg::data_width-1:0]     ex_rega,
    output logic [decode_pkg::data_width-1:0]     ex_regb,
    output logic [decode_pkg::data_width-1:0]     ex_imm,
    output logic [4:0]                            ex_shamt
);

    logic        accept;
    logic [15:0] imm;

    // Empty, or draining into execute this cycle
    assign in_ready = !ex_valid || ex_ready;
    assign accept   = in_valid && in_ready;
    assign imm      = instruction[decode_pkg::imm_msb:decode_pkg::imm_lsb];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_valid         <= 1'b0;
            ex_alu_op        <= decode_pkg::alu_add;
            ex_shift_op      <= decode_pkg::shift_sll;
            ex_use_shift     <= 1'b0;
            ex_use_imm       <= 1'b0;
            ex_unsigned      <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_mem_write     <= 1'b0;
            ex_wb_from_mem   <= 1'b0;
            ex_write_reg     <= 1'b0;
            ex_trap_overflow <= 1'b0;
        end else if (accept) begin
            ex_valid         <= 1'b1;
            ex_alu_op        <= ctrl.alu_op;
            ex_shift_op      <= ctrl.shift_op;
            ex_use_shift     <= ctrl.use_shift;
            ex_use_imm       <= ctrl.use_imm;
            ex_unsigned      <= ctrl.unsigned_op;
            ex_mem_read      <= ctrl.mem_read;
            ex_mem_write     <= ctrl.mem_write;
            ex_wb_from_mem   <= ctrl.wb_from_mem;
            ex_write_reg     <= ctrl.write_reg;
            ex_trap_overflow <= ctrl.trap_overflow;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ex_rega  <= rs_data;
            ex_regb  <= rt_data;
            ex_imm   <= ctrl.zero_ext_imm ? {16'h0000, imm} : {{16{imm[15]}}, imm};
            ex_shamt <= instruction[decode_pkg::shamt_msb:decode_pkg::shamt_lsb];
            ex_dest  <= ctrl.dest_is_rd ? instruction[decode_pkg::rd_msb:decode_pkg::rd_lsb]
                                        : instruction[decode_pkg::rt_msb:decode_pkg::rt_lsb];
        end
    end

endmodule

/* verilog/register_file.sv */
module register_file (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [decode_pkg::reg_addr_width-1:0] addr_a,
    input  logic [decode_pkg::reg_addr_width-1:0] addr_b,
    output logic [decode_pkg::data_width-1:0]     data_a,
    output logic [decode_pkg::data_width-1:0]     data_b,
    input  logic                                  write,
    input  logic [decode_pkg::reg_addr_width-1:0] write_addr,
    input  logic [decode_pkg::data_width-1:0]     write_data
);

    logic [decode_pkg::data_width-1:0] regs [1:31];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Register 0 always reads as zero
    assign data_a = (addr_a == '0) ? '0 : regs[addr_a];
    assign data_b = (addr_b == '0) ? '0 : regs[addr_b];

endmodule
